/* rtl/hex_stream_pkg.sv */
// hex stream package
// line layout constants, ascii codes and state encodings shared by
// the pattern transmitter blocks

package hex_stream_pkg;

	// line layout
	localparam int hex_digits  = 16; // characters per hex group
	localparam int line_chars  = 64; // printable characters per line
	localparam int line_length = 66; // printable characters plus cr and lf
	localparam int index_width = 7;  // enough for 0..65

	// ascii codes
	localparam logic [7:0] ascii_cr          = 8'h0d;
	localparam logic [7:0] ascii_lf          = 8'h0a;
	localparam logic [7:0] ascii_zero        = 8'h30;
	localparam logic [7:0] ascii_a_minus_ten = 8'd87; // 'a' lands on digit 10

	// sequencer states
	typedef enum logic [1:0] {
		seq_idle      = 2'd0, // paused, enable low
		seq_wait_tick = 2'd1, // waiting for a tick with the line free
		seq_strobe    = 2'd2, // formatter settles, strobe goes out
		seq_wait_busy = 2'd3  // waiting for the transmitter to pick it up
	} seq_state_t;

	// transmitter states
	typedef enum logic [1:0] {
		tx_idle  = 2'd0,
		tx_start = 2'd1,
		tx_data  = 2'd2,
		tx_stop  = 2'd3
	} tx_state_t;

endpackage

/* rtl/send_pacer.sv */
// send pacer
// free-running timer, one pace tick per 2**(pace_bits+1) cycles
// first tick a full period after reset

module send_pacer #(
	parameter int pace_bits = 15
) (
	input  logic clock,
	input  logic reset,
	output logic pace_tick
);

	logic [pace_bits:0] count;
	logic               wrap;

	// about to roll over to zero
	assign wrap = &count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count     <= '0;
			pace_tick <= 1'b0;
		end else begin
			count     <= count + 1'b1; // wraps naturally
			pace_tick <= wrap;         // high in the cycle count reads zero
		end
	end

endmodule

/* rtl/pattern_sequencer.sv */
// pattern sequencer
// steps the character index on accepted pace ticks and strobes the
// transmitter one cycle later, once the formatter has the new code

module pattern_sequencer (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   enable,
	input  logic                                   pace_tick,
	input  logic                                   busy,
	output logic [hex_stream_pkg::index_width-1:0] char_index,
	output logic                                   char_strobe
);

	localparam int iw = hex_stream_pkg::index_width;
	localparam logic [iw-1:0] last_index = iw'(hex_stream_pkg::line_length - 1);

	hex_stream_pkg::seq_state_t state;
	logic                       accept;
	logic [iw-1:0]              next_index;

	// a tick only counts with the line free and the stream enabled
	assign accept = (state == hex_stream_pkg::seq_wait_tick) && enable && pace_tick && !busy;

	assign next_index = (char_index == last_index) ? '0 : char_index + 1'b1; // 65 -> 0

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= hex_stream_pkg::seq_idle;
			char_index  <= last_index; // first character out is '0'
			char_strobe <= 1'b0;
		end else begin
			char_strobe <= 1'b0; // single cycle pulse
			case (state)
				hex_stream_pkg::seq_idle: begin
					if (enable) begin
						state <= hex_stream_pkg::seq_wait_tick;
					end
				end
				hex_stream_pkg::seq_wait_tick: begin
					if (!enable) begin
						state <= hex_stream_pkg::seq_idle; // pause between characters
					end else if (accept) begin
						char_index <= next_index;
						state      <= hex_stream_pkg::seq_strobe;
					end
				end
				hex_stream_pkg::seq_strobe: begin
					// formatter registers the new code in this same edge
					char_strobe <= 1'b1;
					state       <= hex_stream_pkg::seq_wait_busy;
				end
				hex_stream_pkg::seq_wait_busy: begin
					// busy falling is covered by the accept condition
					if (busy) begin
						state <= hex_stream_pkg::seq_wait_tick;
					end
				end
				default: state <= hex_stream_pkg::seq_idle;
			endcase
		end
	end

	// never strobe into a frame that is still going out
	strobe_while_busy: assert property (
		@(posedge clock) disable iff (reset) char_strobe |-> !busy
	);

	index_in_range: assert property (
		@(posedge clock) disable iff (reset) char_index <= last_index
	);

endmodule

/* rtl/ascii_formatter.sv */
// ascii formatter
// registered map from character index to a lower case hex digit,
// cr at index 64 and lf at index 65

module ascii_formatter (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic [hex_stream_pkg::index_width-1:0] char_index,
	output logic [7:0]                             char_data
);

	logic [3:0] digit;
	logic [7:0] next_code;

	// position within the current hex group
	assign digit = 4'(char_index % hex_stream_pkg::hex_digits);

	always_comb begin
		if (char_index < hex_stream_pkg::line_chars) begin
			if (digit < 4'd10) begin
				next_code = hex_stream_pkg::ascii_zero + 8'(digit); // 0-9
			end else begin
				next_code = hex_stream_pkg::ascii_a_minus_ten + 8'(digit); // a-f
			end
		end else if (char_index == hex_stream_pkg::line_chars) begin
			next_code = hex_stream_pkg::ascii_cr;
		end else begin
			// index 65, the line end
			next_code = hex_stream_pkg::ascii_lf;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			char_data <= hex_stream_pkg::ascii_lf; // matches index 65 after reset
		end else begin
			char_data <= next_code;
		end
	end

endmodule

/* rtl/uart_tx.sv */
// uart transmitter
// 8N1 serializer, lsb first, busy from start bit to end of stop bit

module uart_tx #(
	parameter int clocks_per_bit = 104
) (
	input  logic       clock,
	input  logic       reset,
	input  logic       char_strobe,
	input  logic [7:0] char_data,
	output logic       tx,
	output logic       busy
);

	localparam int cw = (clocks_per_bit > 1) ? $clog2(clocks_per_bit) : 1;
	localparam logic [cw-1:0] last_count = cw'(clocks_per_bit - 1);

	hex_stream_pkg::tx_state_t state;
	logic [cw-1:0]             count;     // clocks within the current bit
	logic [2:0]                bit_count; // data bit being sent
	logic [7:0]                shift;
	logic                      bit_done;

	assign bit_done = (count == last_count);

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= hex_stream_pkg::tx_idle;
			count     <= '0;
			bit_count <= '0;
			tx        <= 1'b1; // line idles high
			busy      <= 1'b0;
		end else begin
			count <= bit_done ? '0 : count + 1'b1;
			case (state)
				hex_stream_pkg::tx_idle: begin
					count <= '0;
					if (char_strobe) begin
						state <= hex_stream_pkg::tx_start;
						tx    <= 1'b0; // start bit
						busy  <= 1'b1;
					end
				end
				hex_stream_pkg::tx_start: begin
					if (bit_done) begin
						state     <= hex_stream_pkg::tx_data;
						tx        <= shift[0];
						bit_count <= '0;
					end
				end
				hex_stream_pkg::tx_data: begin
					if (bit_done) begin
						if (bit_count == 3'd7) begin
							state <= hex_stream_pkg::tx_stop;
							tx    <= 1'b1; // stop bit
						end else begin
							tx        <= shift[bit_count + 1'b1];
							bit_count <= bit_count + 1'b1;
						end
					end
				end
				hex_stream_pkg::tx_stop: begin
					if (bit_done) begin
						state <= hex_stream_pkg::tx_idle;
						busy  <= 1'b0;
					end
				end
				default: state <= hex_stream_pkg::tx_idle;
			endcase
		end
	end

	// byte held for the whole frame
	always_ff @(posedge clock) begin
		if (state == hex_stream_pkg::tx_idle && char_strobe) begin
			shift <= char_data;
		end
	end

	idle_line_high: assert property (
		@(posedge clock) disable iff (reset) (state == hex_stream_pkg::tx_idle) |-> tx
	);

endmodule

/* rtl/hex_stream_top.sv */
// hex stream transmitter top level
// pacer, sequencer, formatter and uart tx sending repeated hex lines

module hex_stream_top #(
	parameter int clocks_per_bit = 104,
	parameter int pace_bits      = 15
) (
	input  logic       clock,
	input  logic       reset,
	input  logic       enable,
	output logic       tx,
	output logic       busy,
	output logic       char_strobe,
	output logic [7:0] char_data
);

	logic                                   pace_tick;
	logic [hex_stream_pkg::index_width-1:0] char_index;

	send_pacer #(
		.pace_bits(pace_bits)
	) pacer (
		.clock     (clock),
		.reset     (reset),
		.pace_tick (pace_tick)
	);

	pattern_sequencer sequencer (
		.clock       (clock),
		.reset       (reset),
		.enable      (enable),
		.pace_tick   (pace_tick),
		.busy        (busy),
		.char_index  (char_index),
		.char_strobe (char_strobe)
	);

	ascii_formatter formatter (
		.clock      (clock),
		.reset      (reset),
		.char_index (char_index),
		.char_data  (char_data)
	);

	uart_tx #(
		.clocks_per_bit(clocks_per_bit)
	) transmitter (
		.clock       (clock),
		.reset       (reset),
		.char_strobe (char_strobe),
		.char_data   (char_data),
		.tx          (tx),
		.busy        (busy)
	);

endmodule

/* verification/hex_stream_tb.sv */
// hex stream testbench
// drives enable phases from the stim file, decodes the serial line
// and checks characters, strobe timing and busy length

module hex_stream_tb;

	localparam int clocks_per_bit = 8;
	localparam int pace_bits      = 7;
	localparam int frame_cycles   = 10 * clocks_per_bit;
	localparam int pace_period    = 2 ** (pace_bits + 1);
	localparam int period         = 100;
	localparam int reset_cycles   = 16;
	localparam int max_phases     = 32;
	localparam int max_chars      = 160;
	localparam int char_base      = 'h40; // character section of the stim file

	logic       clock;
	logic       reset;
	logic       enable;
	logic       tx;
	logic       busy;
	logic       char_strobe;
	logic [7:0] char_data;

	logic [31:0] stim_mem [0:255];
	logic        phase_level [0:max_phases-1];
	int          phase_length [0:max_phases-1];
	logic [7:0]  expected_chars [0:max_chars-1];
	int          phase_count;
	int          phase_total;
	int          char_count;
	bit          stim_loaded;

	logic [7:0]  strobe_bytes [$]; // char_data at each strobe, oldest first
	int          decoded;          // frames decoded so far
	int          error_count;
	int          cycle;            // negedges since reset release
	int          last_strobe;
	int          busy_run;         // length of the current busy pulse
	logic        strobe_prev;
	logic        enable_prev;      // enable seen one negedge earlier

	hex_stream_top #(
		.clocks_per_bit(clocks_per_bit),
		.pace_bits     (pace_bits)
	) UUT (
		.clock       (clock),
		.reset       (reset),
		.enable      (enable),
		.tx          (tx),
		.busy        (busy),
		.char_strobe (char_strobe),
		.char_data   (char_data)
	);

	initial clock = 1'b0;
	always #(period / 2) clock = ~clock;

	task automatic abort_run();
		error_count++;
		$display("FAIL: see errors above");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(string name, int expected, int got);
		assert (got == expected) else begin
			$display("Mismatch at time %0t: %s expected 'h%0h, got 'h%0h",
				$time, name, expected, got);
			abort_run();
		end
	endtask

	task automatic load_stimulus();
		int i;
		$readmemh("verification/hex_stream_stim.txt", stim_mem);
		phase_count = int'(stim_mem[0]);
		char_count  = int'(stim_mem[char_base]);
		assert (phase_count > 0 && phase_count <= max_phases &&
			char_count > 0 && char_count <= max_chars) else begin
			$display("Error: stim file holds an invalid phase or character count");
			abort_run();
		end
		phase_total = 0;
		for (i = 0; i < phase_count; i++) begin
			phase_level[i]  = stim_mem[1 + 2 * i][0];
			phase_length[i] = int'(stim_mem[2 + 2 * i]);
			phase_total += phase_length[i];
		end
		for (i = 0; i < char_count; i++) begin
			expected_chars[i] = stim_mem[char_base + 1 + i][7:0];
		end
		stim_loaded = 1'b1;
	endtask

	// each phase holds its level for the given number of cycles
	task automatic drive_enable_phases();
		int p;
		for (p = 0; p < phase_count; p++) begin
			@(negedge clock);
			enable <= phase_level[p];
			repeat (phase_length[p] - 1) @(negedge clock);
		end
		@(negedge clock);
		enable <= 1'b1; // free running until the last character
	endtask

	task automatic check_frame_byte(logic [7:0] value);
		logic [7:0] sent;
		assert (strobe_bytes.size() > 0) else begin
			$display("Error at time %0t: frame on tx without a strobe before it", $time);
			abort_run();
		end
		sent = strobe_bytes.pop_front();
		check_value("tx byte vs char_data", sent, value);
		if (decoded < char_count) begin
			check_value("tx character", expected_chars[decoded], value);
		end
		decoded++;
	endtask

	initial begin
		error_count = 0;
		decoded     = 0;
		reset       = 1'b1;
		enable      = 1'b0;
		load_stimulus();
		repeat (reset_cycles) @(negedge clock);
		// outputs at their reset values
		check_value("tx", 1, tx);
		check_value("busy", 0, busy);
		check_value("char_strobe", 0, char_strobe);
		check_value("char_data", 8'h0a, char_data);
		reset <= 1'b0;
		drive_enable_phases();
		wait (decoded >= char_count);
		@(negedge clock);
		if (error_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			abort_run();
		end
	end

	// strobe, busy and start bit timing, sampled between clock edges
	always @(negedge clock) begin
		if (reset) begin
			cycle       = 0;
			last_strobe = -1;
			busy_run    = 0;
			strobe_prev = 1'b0;
			enable_prev = 1'b0;
		end else begin
			cycle = cycle + 1;
			if (strobe_prev) begin
				// start bit the cycle after the strobe
				check_value("tx after strobe", 0, tx);
				check_value("busy after strobe", 1, busy);
			end
			if (char_strobe) begin
				check_value("busy at strobe", 0, busy);
				check_value("enable at accepting tick", 1, enable_prev);
				if (last_strobe >= 0) begin
					assert ((cycle - last_strobe) % pace_period == 0) else begin
						$display("Error at %0t: strobe spacing %0d is not a multiple of %0d",
							$time, cycle - last_strobe, pace_period);
						abort_run();
					end
				end
				last_strobe = cycle;
				strobe_bytes.push_back(char_data);
			end
			if (busy) begin
				busy_run = busy_run + 1;
			end else if (busy_run != 0) begin
				check_value("busy length", frame_cycles, busy_run);
				busy_run = 0;
			end
			strobe_prev = char_strobe;
			enable_prev = enable;
		end
	end

	// serial decoder, samples near the centre of each bit
	initial begin : decode_frames
		logic [7:0] byte_value;
		int         b;
		forever begin
			@(negedge clock);
			if (!reset && tx == 1'b0) begin
				repeat (clocks_per_bit / 2 - 1) @(negedge clock);
				check_value("tx start bit", 0, tx);
				for (b = 0; b < 8; b++) begin
					repeat (clocks_per_bit) @(negedge clock);
					byte_value[b] = tx; // lsb first
				end
				repeat (clocks_per_bit) @(negedge clock);
				check_value("tx stop bit", 1, tx);
				check_frame_byte(byte_value);
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (stim_loaded);
		limit = reset_cycles + phase_total + 200 * frame_cycles;
		repeat (limit) @(posedge clock);
		$display("Timeout: only %0d of %0d characters decoded after %0d cycles",
			decoded, char_count, limit);
		abort_run();
	end

endmodule

/* verification/hex_stream_stim.txt */
// @00: phase count, then one line per phase: enable level, hold length in cycles (hex)
// @40: character count, then the expected ascii codes in send order (hex)
@00
7
1 1f40
0 07d0
1 0082
0 0309
1 2ee0
0 0bb8
1 2328
@40
8c
30 31 32 33 34 35 36 37 38 39 61 62 63 64 65 66
30 31 32 33 34 35 36 37 38 39 61 62 63 64 65 66
30 31 32 33 34 35 36 37 38 39 61 62 63 64 65 66
30 31 32 33 34 35 36 37 38 39 61 62 63 64 65 66
0d 0a
30 31 32 33 34 35 36 37 38 39 61 62 63 64 65 66
30 31 32 33 34 35 36 37 38 39 61 62 63 64 65 66
30 31 32 33 34 35 36 37 38 39 61 62 63 64 65 66
30 31 32 33 34 35 36 37 38 39 61 62 63 64 65 66
0d 0a
30 31 32 33 34 35 36 37

/* compile.f */
rtl/hex_stream_pkg.sv
rtl/send_pacer.sv
rtl/pattern_sequencer.sv
rtl/ascii_formatter.sv
rtl/uart_tx.sv
rtl/hex_stream_top.sv
verification/hex_stream_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = hex_stream_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
